//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert -Wno-fatal
TOP      = mem_subsystem_tb
FILELIST = compile.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- compile.f
+incdir+verilog
verilog/mem_req_pkg.sv
verilog/axi_lite_pkg.sv
verilog/mem_req_if.sv
verilog/read_arbiter.sv
verilog/axi_lite_read_engine.sv
verilog/axi_lite_write_engine.sv
verilog/mem_subsystem_top.sv
verif/mem_subsystem_tb.sv

//--- verif/mem_subsystem_tb.sv
/*
 * Memory subsystem testbench
 * AXI4-Lite memory model, vector-driven fetch/load/store/flush traffic
 * and response checking
 */

`timescale 1ns/1ps

module mem_subsystem_tb import mem_req_pkg::*, axi_lite_pkg::*; ();

  localparam int unsigned WAIT_LIMIT = 200;
  // Data access, secure, unprivileged
  localparam logic [2:0] PROT_DATA_UNPRIV = 3'b000;

  logic      clk_i;
  logic      rst_ni;
  logic      fetch_req_valid_i;
  logic      fetch_req_ready_o;
  mem_addr_t fetch_addr_i;
  logic      fetch_rsp_valid_o;
  mem_data_t fetch_rsp_data_o;
  logic      fetch_rsp_err_o;
  logic      load_req_valid_i;
  logic      load_req_ready_o;
  mem_addr_t load_addr_i;
  logic      load_rsp_valid_o;
  mem_data_t load_rsp_data_o;
  logic      load_rsp_err_o;
  logic      store_req_valid_i;
  logic      store_req_ready_o;
  mem_addr_t store_addr_i;
  mem_data_t store_wdata_i;
  mem_strb_t store_wstrb_i;
  logic      store_rsp_valid_o;
  logic      store_rsp_err_o;
  logic      flush_i;
  logic      flush_ack_o;
  logic      wbuf_empty_o;
  mem_addr_t m_axi_araddr_o;
  axi_prot_t m_axi_arprot_o;
  logic      m_axi_arvalid_o;
  logic      m_axi_arready_i;
  mem_data_t m_axi_rdata_i;
  axi_resp_e m_axi_rresp_i;
  logic      m_axi_rvalid_i;
  logic      m_axi_rready_o;
  mem_addr_t m_axi_awaddr_o;
  axi_prot_t m_axi_awprot_o;
  logic      m_axi_awvalid_o;
  logic      m_axi_awready_i;
  mem_data_t m_axi_wdata_o;
  mem_strb_t m_axi_wstrb_o;
  logic      m_axi_wvalid_o;
  logic      m_axi_wready_i;
  axi_resp_e m_axi_bresp_i;
  logic      m_axi_bvalid_i;
  logic      m_axi_bready_o;

  integer      seed = 32'he94f;
  logic [31:0] mem_words [256];
  // Expected error bits of stores still in flight
  logic        store_err_q [$];

  mem_subsystem_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic fail_run(input string what);
    $display("[ERROR] at %0t ns: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, expected,
               actual);
      $display("Simulation failed");
      $fatal(1, "run stopped");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite memory model
  ////////////////////////////////////////////////////////////
  initial begin : read_slave
    int unsigned dly;
    int unsigned n;
    logic [31:0] addr;
    m_axi_arready_i = 1'b0;
    m_axi_rvalid_i  = 1'b0;
    m_axi_rdata_i   = '0;
    m_axi_rresp_i   = OKAY;
    forever begin
      @(posedge clk_i);
      if (rst_ni && m_axi_arvalid_o) begin
        addr = m_axi_araddr_o;
        check_value("m_axi_arprot_o", 32'(PROT_DATA_UNPRIV), 32'(m_axi_arprot_o));
        dly  = $unsigned($random(seed)) % 4;
        repeat (dly) @(posedge clk_i);
        m_axi_arready_i <= 1'b1;
        @(posedge clk_i);
        m_axi_arready_i <= 1'b0;
        dly = $unsigned($random(seed)) % 4;
        repeat (dly) @(posedge clk_i);
        m_axi_rvalid_i <= 1'b1;
        if (addr < 32'h400) begin
          m_axi_rdata_i <= mem_words[addr[9:2]];
          m_axi_rresp_i <= OKAY;
        end else begin
          m_axi_rdata_i <= '0;
          m_axi_rresp_i <= SLVERR;
        end
        n = 0;
        do begin
          @(posedge clk_i);
          n++;
          if (n > WAIT_LIMIT) fail_run("read data was never accepted by the DUT");
        end while (!m_axi_rready_o);
        m_axi_rvalid_i <= 1'b0;
      end
    end
  end

  initial begin : write_slave
    int unsigned dly;
    int unsigned n;
    int          i;
    int          b;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    m_axi_awready_i = 1'b0;
    m_axi_wready_i  = 1'b0;
    m_axi_bvalid_i  = 1'b0;
    m_axi_bresp_i   = OKAY;
    for (i = 0; i < 256; i++) begin
      mem_words[i] = 32'(i) ^ 32'ha5a5_0000;
    end
    forever begin
      @(posedge clk_i);
      if (rst_ni && m_axi_awvalid_o && m_axi_wvalid_o) begin
        addr = m_axi_awaddr_o;
        data = m_axi_wdata_o;
        strb = m_axi_wstrb_o;
        check_value("m_axi_awprot_o", 32'(PROT_DATA_UNPRIV), 32'(m_axi_awprot_o));
        // AW first, then W, each after its own delay
        dly  = $unsigned($random(seed)) % 4;
        repeat (dly) @(posedge clk_i);
        m_axi_awready_i <= 1'b1;
        @(posedge clk_i);
        m_axi_awready_i <= 1'b0;
        dly = $unsigned($random(seed)) % 4;
        repeat (dly) @(posedge clk_i);
        m_axi_wready_i <= 1'b1;
        @(posedge clk_i);
        m_axi_wready_i <= 1'b0;
        if (addr < 32'h400) begin
          for (b = 0; b < 4; b++) begin
            if (strb[b]) mem_words[addr[9:2]][8*b +: 8] = data[8*b +: 8];
          end
          m_axi_bresp_i <= OKAY;
        end else begin
          m_axi_bresp_i <= SLVERR;
        end
        dly = $unsigned($random(seed)) % 4;
        repeat (dly) @(posedge clk_i);
        m_axi_bvalid_i <= 1'b1;
        n = 0;
        do begin
          @(posedge clk_i);
          n++;
          if (n > WAIT_LIMIT) fail_run("write response was never accepted by the DUT");
        end while (!m_axi_bready_o);
        m_axi_bvalid_i <= 1'b0;
      end
    end
  end

  // Store responses come back in issue order
  always @(posedge clk_i) begin
    if (rst_ni && store_rsp_valid_o) begin
      if (store_err_q.size() == 0) begin
        fail_run("store response arrived with no store in flight");
      end else begin
        check_value("store_rsp_err_o", 32'(store_err_q.pop_front()), 32'(store_rsp_err_o));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Request tasks
  ////////////////////////////////////////////////////////////
  task automatic run_reads(input logic do_fetch, input logic do_load, input logic [31:0] addr,
                           input logic [31:0] exp_data, input logic exp_err);
    logic        f_done;
    logic        l_done;
    int unsigned n;
    f_done = !do_fetch;
    l_done = !do_load;
    fetch_req_valid_i <= do_fetch;
    fetch_addr_i      <= addr;
    load_req_valid_i  <= do_load;
    load_addr_i       <= addr;
    n = 0;
    while (!(f_done && l_done)) begin
      @(posedge clk_i);
      n++;
      if (n > WAIT_LIMIT) begin
        if (!f_done) fail_run("fetch response never arrived");
        else fail_run("load response never arrived");
      end
      if (fetch_req_ready_o) fetch_req_valid_i <= 1'b0;
      if (load_req_ready_o) begin
        // Loads are held back until the write path is empty
        check_value("wbuf_empty_o", 32'd1, 32'(wbuf_empty_o));
        load_req_valid_i <= 1'b0;
      end
      if (fetch_rsp_valid_o) begin
        check_value("fetch_rsp_valid_o", 32'(!f_done), 32'd1);
        check_value("fetch_rsp_data_o", exp_data, fetch_rsp_data_o);
        check_value("fetch_rsp_err_o", 32'(exp_err), 32'(fetch_rsp_err_o));
        f_done = 1'b1;
      end
      if (load_rsp_valid_o) begin
        check_value("load_rsp_valid_o", 32'(!l_done), 32'd1);
        check_value("load_rsp_data_o", exp_data, load_rsp_data_o);
        check_value("load_rsp_err_o", 32'(exp_err), 32'(load_rsp_err_o));
        // Fetch has priority, so its pulse must already be done
        check_value("fetch_rsp_valid_o", 32'd1, 32'(f_done));
        l_done = 1'b1;
      end
    end
  endtask

  task automatic send_store(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, input logic exp_err);
    int unsigned n;
    store_req_valid_i <= 1'b1;
    store_addr_i      <= addr;
    store_wdata_i     <= wdata;
    store_wstrb_i     <= strb;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > WAIT_LIMIT) fail_run("store request was never accepted");
    end while (!store_req_ready_o);
    store_req_valid_i <= 1'b0;
    store_err_q.push_back(exp_err);
  endtask

  task automatic drain_stores();
    int unsigned n;
    n = 0;
    while (store_err_q.size() != 0) begin
      @(posedge clk_i);
      n++;
      if (n > WAIT_LIMIT) fail_run("store response never arrived");
    end
  endtask

  task automatic flush_during_store(input logic [31:0] addr, input logic [31:0] wdata,
                                    input logic [3:0] strb, input logic exp_err);
    logic        rsp_seen;
    int unsigned n;
    drain_stores();
    rsp_seen = 1'b0;
    flush_i <= 1'b1;
    send_store(addr, wdata, strb, exp_err);
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > WAIT_LIMIT) fail_run("flush acknowledge never arrived");
      if (!rsp_seen) check_value("flush_ack_o", 32'd0, 32'(flush_ack_o));
      if (flush_ack_o) check_value("wbuf_empty_o", 32'd1, 32'(wbuf_empty_o));
      if (store_rsp_valid_o) rsp_seen = 1'b1;
    end while (!flush_ack_o);
    flush_i <= 1'b0;
    repeat (4) begin
      @(posedge clk_i);
      check_value("flush_ack_o", 32'd0, 32'(flush_ack_o));
    end
  endtask

  task automatic check_reset_state();
    check_value("m_axi_arvalid_o", 32'd0, 32'(m_axi_arvalid_o));
    check_value("m_axi_awvalid_o", 32'd0, 32'(m_axi_awvalid_o));
    check_value("m_axi_wvalid_o", 32'd0, 32'(m_axi_wvalid_o));
    check_value("fetch_rsp_valid_o", 32'd0, 32'(fetch_rsp_valid_o));
    check_value("load_rsp_valid_o", 32'd0, 32'(load_rsp_valid_o));
    check_value("store_rsp_valid_o", 32'd0, 32'(store_rsp_valid_o));
    check_value("flush_ack_o", 32'd0, 32'(flush_ack_o));
    check_value("wbuf_empty_o", 32'd1, 32'(wbuf_empty_o));
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin : main_seq
    int          fd;
    int          code;
    int unsigned n_ops;
    string       line;
    logic [63:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] strb;
    logic [31:0] exp_data;
    logic [31:0] exp_err;
    rst_ni            = 1'b0;
    fetch_req_valid_i = 1'b0;
    fetch_addr_i      = '0;
    load_req_valid_i  = 1'b0;
    load_addr_i       = '0;
    store_req_valid_i = 1'b0;
    store_addr_i      = '0;
    store_wdata_i     = '0;
    store_wstrb_i     = '0;
    flush_i           = 1'b0;
    n_ops             = 0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_reset_state();

    fd = $fopen("verif/mem_subsystem_vectors.txt", "r");
    if (fd == 0) fail_run("cannot open the vector file");
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line[0] == "#") continue;
      code = $sscanf(line, "%s %h %h %h %h %h", op, addr, wdata, strb, exp_data, exp_err);
      if (code != 6) fail_run("malformed line in the vector file");
      n_ops++;
      case (op)
        "fetch": run_reads(1'b1, 1'b0, addr, exp_data, exp_err[0]);
        "load":  run_reads(1'b0, 1'b1, addr, exp_data, exp_err[0]);
        "both":  run_reads(1'b1, 1'b1, addr, exp_data, exp_err[0]);
        "store": send_store(addr, wdata, strb[3:0], exp_err[0]);
        "flush": flush_during_store(addr, wdata, strb[3:0], exp_err[0]);
        default: fail_run("unknown operation in the vector file");
      endcase
    end
    $fclose(fd);
    if (n_ops == 0) fail_run("no operations were read from the vector file");

    drain_stores();
    @(posedge clk_i);
    check_value("wbuf_empty_o", 32'd1, 32'(wbuf_empty_o));
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- verif/mem_subsystem_vectors.txt
# op    addr     wdata    strb exp_data exp_err   (all fields hex, exp_data unused for stores)
# ops: fetch, load, store, flush (store with flush held high), both (fetch and load together)
fetch 00000000 00000000 0 a5a50000 0
load  000003fc 00000000 0 a5a500ff 0
store 00000040 11223344 3 00000000 0
load  00000040 00000000 0 a5a53344 0
store 00000044 deadbeef c 00000000 0
load  00000044 00000000 0 dead0011 0
both  00000080 00000000 0 a5a50020 0
both  000000c4 00000000 0 a5a50031 0
fetch 00000400 00000000 0 00000000 1
load  00000800 00000000 0 00000000 1
store 00000400 cafef00d f 00000000 1
flush 00000048 0badf00d f 00000000 0
load  00000048 00000000 0 0badf00d 0
store 00000100 12345678 1 00000000 0
load  00000100 00000000 0 a5a50078 0

//--- verilog/axi_lite_pkg.sv
/*
 * AXI4-Lite types
 * Response codes, protection field and channel payloads
 */

`include "mem_subsys_config.svh"

package axi_lite_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef logic [2:0] axi_prot_t;

  typedef struct packed {
    logic [`MEM_DATA_WIDTH-1:0] data;
    axi_resp_e                  resp;
  } axi_r_chan_t;

  typedef struct packed {
    logic [`MEM_DATA_WIDTH-1:0] data;
    logic [`MEM_STRB_WIDTH-1:0] strb;
  } axi_w_chan_t;

endpackage

//--- verilog/axi_lite_read_engine.sv
/*
 * AXI4-Lite read engine
 * One outstanding read, AR then R, result returned as a one-cycle pulse
 */

`timescale 1ns/1ps

module axi_lite_read_engine import mem_req_pkg::*, axi_lite_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  mem_req_if.responder req,
  output mem_addr_t m_axi_araddr_o,
  output logic      m_axi_arvalid_o,
  input  logic      m_axi_arready_i,
  input  mem_data_t m_axi_rdata_i,
  input  axi_resp_e m_axi_rresp_i,
  input  logic      m_axi_rvalid_i,
  output logic      m_axi_rready_o
);

  eng_state_e  state_q;
  eng_state_e  state_d;
  logic        rsp_valid_q;
  mem_req_t    req_q;
  axi_r_chan_t r_q;
  logic        req_hs;
  logic        ar_hs;
  logic        r_hs;

  assign req_hs = req.req_valid && req.req_ready;
  assign ar_hs  = m_axi_arvalid_o && m_axi_arready_i;
  assign r_hs   = m_axi_rvalid_i && m_axi_rready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ENG_IDLE: begin
        if (req_hs) begin
          state_d = ENG_ADDR;
        end
      end
      ENG_ADDR: begin
        if (ar_hs) begin
          state_d = ENG_WAIT_RESP;
        end
      end
      ENG_WAIT_RESP: begin
        if (r_hs) begin
          state_d = ENG_IDLE;
        end
      end
      default: state_d = ENG_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ENG_IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= r_hs;
    end
  end

  // Request and read data payload
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      req_q <= '{addr: req.req_addr, src: req.req_src};
    end
    if (r_hs) begin
      r_q <= '{data: m_axi_rdata_i, resp: m_axi_rresp_i};
    end
  end

  assign req.req_ready   = (state_q == ENG_IDLE);
  assign m_axi_araddr_o  = req_q.addr;
  assign m_axi_arvalid_o = (state_q == ENG_ADDR);
  assign m_axi_rready_o  = (state_q == ENG_WAIT_RESP);

  assign req.rsp_valid = rsp_valid_q;
  assign req.rsp_data  = r_q.data;
  assign req.rsp_err   = (r_q.resp != OKAY);
  assign req.rsp_src   = req_q.src;

  a_arvalid_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o)
  );

endmodule

//--- verilog/axi_lite_write_engine.sv
/*
 * AXI4-Lite write engine
 * One outstanding store, AW and W issued independently, then B.
 * Also acknowledges flushes and reports write-path emptiness
 */

`timescale 1ns/1ps

module axi_lite_write_engine import mem_req_pkg::*, axi_lite_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      store_req_valid_i,
  output logic      store_req_ready_o,
  input  mem_addr_t store_addr_i,
  input  mem_data_t store_wdata_i,
  input  mem_strb_t store_wstrb_i,
  output logic      store_rsp_valid_o,
  output logic      store_rsp_err_o,
  input  logic      flush_i,
  output logic      flush_ack_o,
  output logic      wbuf_empty_o,
  output logic      write_busy_o,
  output mem_addr_t m_axi_awaddr_o,
  output logic      m_axi_awvalid_o,
  input  logic      m_axi_awready_i,
  output mem_data_t m_axi_wdata_o,
  output mem_strb_t m_axi_wstrb_o,
  output logic      m_axi_wvalid_o,
  input  logic      m_axi_wready_i,
  input  axi_resp_e m_axi_bresp_i,
  input  logic      m_axi_bvalid_i,
  output logic      m_axi_bready_o
);

  eng_state_e  state_q;
  eng_state_e  state_d;
  logic        aw_sent_q;
  logic        w_sent_q;
  logic        rsp_valid_q;
  logic        rsp_err_q;
  logic        flush_ack_q;
  mem_addr_t   aw_addr_q;
  axi_w_chan_t w_q;
  logic        store_hs;
  logic        aw_hs;
  logic        w_hs;
  logic        b_hs;
  logic        engine_idle;

  assign store_hs = store_req_valid_i && store_req_ready_o;
  assign aw_hs    = m_axi_awvalid_o && m_axi_awready_i;
  assign w_hs     = m_axi_wvalid_o && m_axi_wready_i;
  assign b_hs     = m_axi_bvalid_i && m_axi_bready_o;

  // Idle and not taking a new store this cycle
  assign engine_idle = (state_q == ENG_IDLE) && !store_hs;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ENG_IDLE: begin
        if (store_hs) begin
          state_d = ENG_ADDR;
        end
      end
      ENG_ADDR: begin
        if ((aw_sent_q || aw_hs) && (w_sent_q || w_hs)) begin
          state_d = ENG_WAIT_RESP;
        end
      end
      ENG_WAIT_RESP: begin
        if (b_hs) begin
          state_d = ENG_IDLE;
        end
      end
      default: state_d = ENG_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ENG_IDLE;
      aw_sent_q   <= 1'b0;
      w_sent_q    <= 1'b0;
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
      flush_ack_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      aw_sent_q   <= !store_hs && (aw_sent_q || aw_hs);
      w_sent_q    <= !store_hs && (w_sent_q || w_hs);
      rsp_valid_q <= b_hs;
      rsp_err_q   <= b_hs && (m_axi_bresp_i != OKAY);
      flush_ack_q <= flush_i && engine_idle && !flush_ack_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (store_hs) begin
      aw_addr_q <= store_addr_i;
      w_q       <= '{data: store_wdata_i, strb: store_wstrb_i};
    end
  end

  assign store_req_ready_o = (state_q == ENG_IDLE);
  assign store_rsp_valid_o = rsp_valid_q;
  assign store_rsp_err_o   = rsp_err_q;
  assign flush_ack_o       = flush_ack_q;
  assign wbuf_empty_o      = (state_q == ENG_IDLE);
  assign write_busy_o      = (state_q != ENG_IDLE) || store_hs;

  ////////////////////////////////////////////////////////////
  // AXI write channels
  ////////////////////////////////////////////////////////////
  assign m_axi_awaddr_o  = aw_addr_q;
  assign m_axi_awvalid_o = (state_q == ENG_ADDR) && !aw_sent_q;
  assign m_axi_wdata_o   = w_q.data;
  assign m_axi_wstrb_o   = w_q.strb;
  assign m_axi_wvalid_o  = (state_q == ENG_ADDR) && !w_sent_q;
  assign m_axi_bready_o  = (state_q == ENG_WAIT_RESP);

  a_awvalid_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    m_axi_awvalid_o && !m_axi_awready_i |=> m_axi_awvalid_o
  );

  a_wvalid_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    m_axi_wvalid_o && !m_axi_wready_i |=> m_axi_wvalid_o
  );

  a_flush_ack_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_ack_o |-> wbuf_empty_o ##1 !flush_ack_o
  );

endmodule

//--- verilog/mem_req_if.sv
/*
 * Read request/response link
 * Carries merged fetch and load reads from the arbiter to the read engine
 */

`timescale 1ns/1ps

interface mem_req_if import mem_req_pkg::*; ();

  // Request transfers when valid and ready are both high
  logic      req_valid;
  logic      req_ready;
  mem_addr_t req_addr;
  mem_src_e  req_src;

  // One-cycle response pulse without back-pressure
  logic      rsp_valid;
  mem_data_t rsp_data;
  logic      rsp_err;
  mem_src_e  rsp_src;

  modport requester (
    output req_valid,
    output req_addr,
    output req_src,
    input  req_ready,
    input  rsp_valid,
    input  rsp_data,
    input  rsp_err,
    input  rsp_src
  );

  modport responder (
    input  req_valid,
    input  req_addr,
    input  req_src,
    output req_ready,
    output rsp_valid,
    output rsp_data,
    output rsp_err,
    output rsp_src
  );

endinterface

//--- verilog/mem_req_pkg.sv
/*
 * Requester-side types of the memory subsystem
 * Read source, payload types and the engine state encoding
 */

`include "mem_subsys_config.svh"

package mem_req_pkg;

  typedef enum logic {
    SRC_FETCH = 1'b0,
    SRC_LOAD  = 1'b1
  } mem_src_e;

  typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [`MEM_DATA_WIDTH-1:0] mem_data_t;
  typedef logic [`MEM_STRB_WIDTH-1:0] mem_strb_t;

  // Shared by the read and write engines
  typedef enum logic [1:0] {
    ENG_IDLE      = 2'd0,
    ENG_ADDR      = 2'd1,
    ENG_WAIT_RESP = 2'd2
  } eng_state_e;

  typedef struct packed {
    mem_addr_t addr;
    mem_src_e  src;
  } mem_req_t;

endpackage

//--- verilog/mem_subsys_config.svh
/*
 * Memory subsystem configuration
 * Address and data widths and the fixed AXI protection value
 */

`ifndef MEM_SUBSYS_CONFIG_SVH
`define MEM_SUBSYS_CONFIG_SVH

// Byte address and data word widths
`define MEM_ADDR_WIDTH 32
`define MEM_DATA_WIDTH 32
`define MEM_STRB_WIDTH (`MEM_DATA_WIDTH / 8)

// Data access, unprivileged, secure
`define MEM_AXI_PROT_DEFAULT 3'b000

`endif

//--- verilog/mem_subsystem_top.sv
/*
 * Memory subsystem top level
 * Fetch, load and store ports merged onto one AXI4-Lite master
 */

`timescale 1ns/1ps

`include "mem_subsys_config.svh"

module mem_subsystem_top import mem_req_pkg::*, axi_lite_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Fetch port
  input  logic      fetch_req_valid_i,
  output logic      fetch_req_ready_o,
  input  mem_addr_t fetch_addr_i,
  output logic      fetch_rsp_valid_o,
  output mem_data_t fetch_rsp_data_o,
  output logic      fetch_rsp_err_o,
  // Load port
  input  logic      load_req_valid_i,
  output logic      load_req_ready_o,
  input  mem_addr_t load_addr_i,
  output logic      load_rsp_valid_o,
  output mem_data_t load_rsp_data_o,
  output logic      load_rsp_err_o,
  // Store port
  input  logic      store_req_valid_i,
  output logic      store_req_ready_o,
  input  mem_addr_t store_addr_i,
  input  mem_data_t store_wdata_i,
  input  mem_strb_t store_wstrb_i,
  output logic      store_rsp_valid_o,
  output logic      store_rsp_err_o,
  // Flush and status
  input  logic      flush_i,
  output logic      flush_ack_o,
  output logic      wbuf_empty_o,
  // AXI4-Lite read
  output mem_addr_t m_axi_araddr_o,
  output axi_prot_t m_axi_arprot_o,
  output logic      m_axi_arvalid_o,
  input  logic      m_axi_arready_i,
  input  mem_data_t m_axi_rdata_i,
  input  axi_resp_e m_axi_rresp_i,
  input  logic      m_axi_rvalid_i,
  output logic      m_axi_rready_o,
  // AXI4-Lite write
  output mem_addr_t m_axi_awaddr_o,
  output axi_prot_t m_axi_awprot_o,
  output logic      m_axi_awvalid_o,
  input  logic      m_axi_awready_i,
  output mem_data_t m_axi_wdata_o,
  output mem_strb_t m_axi_wstrb_o,
  output logic      m_axi_wvalid_o,
  input  logic      m_axi_wready_i,
  input  axi_resp_e m_axi_bresp_i,
  input  logic      m_axi_bvalid_i,
  output logic      m_axi_bready_o
);

  logic write_busy;

  mem_req_if i_rd_if ();

  assign m_axi_arprot_o = axi_prot_t'(`MEM_AXI_PROT_DEFAULT);
  assign m_axi_awprot_o = axi_prot_t'(`MEM_AXI_PROT_DEFAULT);

  read_arbiter i_read_arbiter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fetch_req_valid_i (fetch_req_valid_i),
    .fetch_req_ready_o (fetch_req_ready_o),
    .fetch_addr_i      (fetch_addr_i),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .fetch_rsp_data_o  (fetch_rsp_data_o),
    .fetch_rsp_err_o   (fetch_rsp_err_o),
    .load_req_valid_i  (load_req_valid_i),
    .load_req_ready_o  (load_req_ready_o),
    .load_addr_i       (load_addr_i),
    .load_rsp_valid_o  (load_rsp_valid_o),
    .load_rsp_data_o   (load_rsp_data_o),
    .load_rsp_err_o    (load_rsp_err_o),
    .write_busy_i      (write_busy),
    .mem               (i_rd_if.requester)
  );

  axi_lite_read_engine i_read_engine (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req             (i_rd_if.responder),
    .m_axi_araddr_o  (m_axi_araddr_o),
    .m_axi_arvalid_o (m_axi_arvalid_o),
    .m_axi_arready_i (m_axi_arready_i),
    .m_axi_rdata_i   (m_axi_rdata_i),
    .m_axi_rresp_i   (m_axi_rresp_i),
    .m_axi_rvalid_i  (m_axi_rvalid_i),
    .m_axi_rready_o  (m_axi_rready_o)
  );

  axi_lite_write_engine i_write_engine (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .store_req_valid_i (store_req_valid_i),
    .store_req_ready_o (store_req_ready_o),
    .store_addr_i      (store_addr_i),
    .store_wdata_i     (store_wdata_i),
    .store_wstrb_i     (store_wstrb_i),
    .store_rsp_valid_o (store_rsp_valid_o),
    .store_rsp_err_o   (store_rsp_err_o),
    .flush_i           (flush_i),
    .flush_ack_o       (flush_ack_o),
    .wbuf_empty_o      (wbuf_empty_o),
    .write_busy_o      (write_busy),
    .m_axi_awaddr_o    (m_axi_awaddr_o),
    .m_axi_awvalid_o   (m_axi_awvalid_o),
    .m_axi_awready_i   (m_axi_awready_i),
    .m_axi_wdata_o     (m_axi_wdata_o),
    .m_axi_wstrb_o     (m_axi_wstrb_o),
    .m_axi_wvalid_o    (m_axi_wvalid_o),
    .m_axi_wready_i    (m_axi_wready_i),
    .m_axi_bresp_i     (m_axi_bresp_i),
    .m_axi_bvalid_i    (m_axi_bvalid_i),
    .m_axi_bready_o    (m_axi_bready_o)
  );

endmodule

//--- verilog/read_arbiter.sv
/*
 * Fixed-priority read arbiter
 * Fetch wins over load, loads wait while a store is in flight,
 * responses are steered back by source
 */

`timescale 1ns/1ps

module read_arbiter import mem_req_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      fetch_req_valid_i,
  output logic      fetch_req_ready_o,
  input  mem_addr_t fetch_addr_i,
  output logic      fetch_rsp_valid_o,
  output mem_data_t fetch_rsp_data_o,
  output logic      fetch_rsp_err_o,
  input  logic      load_req_valid_i,
  output logic      load_req_ready_o,
  input  mem_addr_t load_addr_i,
  output logic      load_rsp_valid_o,
  output mem_data_t load_rsp_data_o,
  output logic      load_rsp_err_o,
  input  logic      write_busy_i,
  mem_req_if.requester mem
);

  logic     lock_q;
  mem_src_e lock_src_q;
  logic     sel_valid;
  mem_src_e sel_src;

  // Grant stays on the pending source until the engine takes it
  always_comb begin
    sel_valid = 1'b0;
    sel_src   = SRC_FETCH;
    if (lock_q) begin
      sel_valid = 1'b1;
      sel_src   = lock_src_q;
    end else if (fetch_req_valid_i) begin
      sel_valid = 1'b1;
      sel_src   = SRC_FETCH;
    end else if (load_req_valid_i && !write_busy_i) begin
      sel_valid = 1'b1;
      sel_src   = SRC_LOAD;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q     <= 1'b0;
      lock_src_q <= SRC_FETCH;
    end else begin
      lock_q     <= sel_valid && !mem.req_ready;
      lock_src_q <= sel_src;
    end
  end

  assign mem.req_valid = sel_valid;
  assign mem.req_src   = sel_src;
  assign mem.req_addr  = (sel_src == SRC_LOAD) ? load_addr_i : fetch_addr_i;

  assign fetch_req_ready_o = sel_valid && mem.req_ready && (sel_src == SRC_FETCH);
  assign load_req_ready_o  = sel_valid && mem.req_ready && (sel_src == SRC_LOAD);

  ////////////////////////////////////////////////////////////
  // Response steering
  ////////////////////////////////////////////////////////////
  assign fetch_rsp_valid_o = mem.rsp_valid && (mem.rsp_src == SRC_FETCH);
  assign fetch_rsp_data_o  = mem.rsp_data;
  assign fetch_rsp_err_o   = mem.rsp_err;
  assign load_rsp_valid_o  = mem.rsp_valid && (mem.rsp_src == SRC_LOAD);
  assign load_rsp_data_o   = mem.rsp_data;
  assign load_rsp_err_o    = mem.rsp_err;

  a_grant_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem.req_valid && !mem.req_ready |=> mem.req_valid && $stable(mem.req_src)
  );

endmodule
